//--- build.f
design/lsu_bus_pkg.sv
design/lsu_op_pkg.sv
design/lsu_access_decode.sv
design/lsu_read_channel.sv
design/lsu_write_channel.sv
design/lsu_wb_stage.sv
design/lsu_top.sv
verif/lsu_tb.sv

//--- design/lsu_access_decode.sv
//****************************
// lsu access decode
// alignment check, start pulses, write strobes and store lanes
//****************************
`timescale 1ns/1ps

module lsu_access_decode
    import lsu_bus_pkg::*, lsu_op_pkg::*;
(
    input  logic      ex_valid,
    input  lsu_op_e   ex_op,
    input  lsu_size_e ex_size,
    input  axi_addr_t ex_operand,
    input  axi_data_t ex_store_data,
    input  logic      read_idle,
    input  logic      write_idle,
    output logic      misaligned,
    output logic      start_read,
    output logic      start_write,
    output axi_strb_t wstrb,
    output axi_data_t wdata_lanes
);

    logic [$clog2(STRB_W)-1:0] byte_off;
    logic                      off_bad;
    logic                      is_mem;
    axi_strb_t                 size_mask;

    assign byte_off = ex_operand[$clog2(STRB_W)-1:0];
    assign is_mem   = (ex_op == OP_LOAD) || (ex_op == OP_STORE);

    // natural alignment only
    always_comb begin
        case (ex_size)
            SIZE_HALF:   off_bad = ex_operand[0];
            SIZE_WORD:   off_bad = |ex_operand[1:0];
            SIZE_DOUBLE: off_bad = |ex_operand[2:0];
            default:     off_bad = 1'b0;
        endcase
    end

    assign misaligned = is_mem & off_bad;

    assign start_read  = ex_valid & (ex_op == OP_LOAD) & ~off_bad & read_idle;
    assign start_write = ex_valid & (ex_op == OP_STORE) & ~off_bad & write_idle;

    //****************************
    // store lanes
    //****************************
    always_comb begin
        case (ex_size)
            SIZE_BYTE: size_mask = 8'h01;
            SIZE_HALF: size_mask = 8'h03;
            SIZE_WORD: size_mask = 8'h0f;
            default:   size_mask = 8'hff;
        endcase
    end

    assign wstrb       = size_mask << byte_off;
    assign wdata_lanes = ex_store_data << {byte_off, 3'b000};

endmodule

//--- design/lsu_bus_pkg.sv
//****************************
// bus definitions
// AXI4-Lite widths and response codes for the lsu master port
//****************************
package lsu_bus_pkg;

    // byte lanes on the 64-bit data bus
    localparam int STRB_W = 8;

    typedef logic [63:0] axi_addr_t;
    typedef logic [STRB_W*8-1:0] axi_data_t;
    typedef logic [STRB_W-1:0] axi_strb_t;
    typedef logic [1:0] axi_resp_t;

    // SLVERR and DECERR are both treated as access faults
    localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

//--- design/lsu_op_pkg.sv
//****************************
// operation definitions
// op kinds, access sizes, trap causes and pipeline fields
//****************************
package lsu_op_pkg;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_LOAD,
        OP_STORE
    } lsu_op_e;

    // encoded as log2 of the byte count
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } lsu_size_e;

    typedef logic [63:0] trap_cause_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [63:0] pc_t;

    localparam trap_cause_t CAUSE_LOAD_MISALIGNED  = 64'd4;
    localparam trap_cause_t CAUSE_LOAD_ACCESS      = 64'd5;
    localparam trap_cause_t CAUSE_STORE_MISALIGNED = 64'd6;
    localparam trap_cause_t CAUSE_STORE_ACCESS     = 64'd7;

endpackage

//--- design/lsu_read_channel.sv
//****************************
// lsu read channel
// AXI4-Lite read FSM with load lane extraction and extension
//****************************
`timescale 1ns/1ps

module lsu_read_channel
    import lsu_bus_pkg::*, lsu_op_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_read,
    input  logic      ex_ready,
    input  axi_addr_t ex_operand,
    input  lsu_size_e ex_size,
    input  logic      ex_signed,
    input  logic      arready,
    input  logic      rvalid,
    input  axi_resp_t rresp,
    input  axi_data_t rdata,
    output logic      arvalid,
    output axi_addr_t araddr,
    output logic      rready,
    output logic      read_idle,
    output logic      read_done,
    output logic      read_err,
    output axi_data_t load_data
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_DATA,
        R_DONE
    } rd_state_e;

    rd_state_e state;
    axi_data_t shifted;
    axi_data_t lane;

    assign araddr    = ex_operand;
    assign rready    = 1'b1;
    assign read_idle = (state == R_IDLE);
    assign read_done = (state == R_DONE);

    // beat is aligned, so move the addressed lane down to bit 0
    assign shifted = rdata >> {ex_operand[2:0], 3'b000};

    always_comb begin
        case (ex_size)
            SIZE_BYTE: lane = {{56{ex_signed & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: lane = {{48{ex_signed & shifted[15]}}, shifted[15:0]};
            SIZE_WORD: lane = {{32{ex_signed & shifted[31]}}, shifted[31:0]};
            default:   lane = shifted;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= R_IDLE;
            arvalid  <= 1'b0;
            read_err <= 1'b0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (start_read) begin
                        state   <= R_ADDR;
                        arvalid <= 1'b1;
                    end
                end
                R_ADDR: begin
                    if (arready) begin
                        state   <= R_DATA;
                        arvalid <= 1'b0;
                    end
                end
                R_DATA: begin
                    if (rvalid) begin
                        state    <= R_DONE;
                        read_err <= (rresp != RESP_OKAY);
                    end
                end
                R_DONE: begin
                    // held until the op leaves for write-back
                    if (ex_ready) begin
                        state    <= R_IDLE;
                        read_err <= 1'b0;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_DATA && rvalid) begin
            load_data <= lane;
        end
    end

endmodule

//--- design/lsu_top.sv
//****************************
// lsu top
// load/store unit with an AXI4-Lite master port
//****************************
`timescale 1ns/1ps

module lsu_top
    import lsu_bus_pkg::*, lsu_op_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // execute side
    input  logic        ex_valid,
    output logic        ex_ready,
    input  lsu_op_e     ex_op,
    input  lsu_size_e   ex_size,
    input  logic        ex_signed,
    input  axi_addr_t   ex_operand,
    input  axi_data_t   ex_store_data,
    input  reg_idx_t    ex_rd,
    input  logic        ex_dest_wen,
    input  pc_t         ex_pc,
    // write-back side
    output logic        wb_valid,
    input  logic        wb_ready,
    output pc_t         wb_pc,
    output reg_idx_t    wb_rd,
    output logic        wb_dest_wen,
    output axi_data_t   wb_data,
    output logic        wb_trap_valid,
    output trap_cause_t wb_trap_cause,
    output axi_addr_t   wb_trap_tval,
    // AXI4-Lite master
    output logic        arvalid,
    input  logic        arready,
    output axi_addr_t   araddr,
    input  logic        rvalid,
    output logic        rready,
    input  axi_resp_t   rresp,
    input  axi_data_t   rdata,
    output logic        awvalid,
    input  logic        awready,
    output axi_addr_t   awaddr,
    output logic        wvalid,
    input  logic        wready,
    output axi_strb_t   wstrb,
    output axi_data_t   wdata,
    input  logic        bvalid,
    output logic        bready,
    input  axi_resp_t   bresp
);

    logic      misaligned;
    logic      start_read;
    logic      start_write;
    axi_strb_t strb_lanes;
    axi_data_t data_lanes;
    logic      read_idle;
    logic      read_done;
    logic      read_err;
    axi_data_t load_data;
    logic      write_idle;
    logic      write_done;
    logic      write_err;
    logic      op_complete;

    // non-memory and misaligned ops finish without the bus
    assign op_complete = ((ex_op != OP_LOAD) && (ex_op != OP_STORE)) | misaligned
                       | ((ex_op == OP_LOAD) & read_done)
                       | ((ex_op == OP_STORE) & write_done);

    assign ex_ready = ex_valid & (~wb_valid | wb_ready) & op_complete;

    lsu_access_decode u_decode (
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_size       (ex_size),
        .ex_operand    (ex_operand),
        .ex_store_data (ex_store_data),
        .read_idle     (read_idle),
        .write_idle    (write_idle),
        .misaligned    (misaligned),
        .start_read    (start_read),
        .start_write   (start_write),
        .wstrb         (strb_lanes),
        .wdata_lanes   (data_lanes)
    );

    lsu_read_channel u_read (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_read (start_read),
        .ex_ready   (ex_ready),
        .ex_operand (ex_operand),
        .ex_size    (ex_size),
        .ex_signed  (ex_signed),
        .arready    (arready),
        .rvalid     (rvalid),
        .rresp      (rresp),
        .rdata      (rdata),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rready     (rready),
        .read_idle  (read_idle),
        .read_done  (read_done),
        .read_err   (read_err),
        .load_data  (load_data)
    );

    lsu_write_channel u_write (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_write (start_write),
        .ex_ready    (ex_ready),
        .ex_operand  (ex_operand),
        .wstrb_in    (strb_lanes),
        .wdata_in    (data_lanes),
        .awready     (awready),
        .wready      (wready),
        .bvalid      (bvalid),
        .bresp       (bresp),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wstrb       (wstrb),
        .wdata       (wdata),
        .bready      (bready),
        .write_idle  (write_idle),
        .write_done  (write_done),
        .write_err   (write_err)
    );

    lsu_wb_stage u_wb (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_ready      (ex_ready),
        .ex_op         (ex_op),
        .ex_operand    (ex_operand),
        .ex_pc         (ex_pc),
        .ex_rd         (ex_rd),
        .ex_dest_wen   (ex_dest_wen),
        .misaligned    (misaligned),
        .read_err      (read_err),
        .write_err     (write_err),
        .load_data     (load_data),
        .wb_ready      (wb_ready),
        .wb_valid      (wb_valid),
        .wb_pc         (wb_pc),
        .wb_rd         (wb_rd),
        .wb_dest_wen   (wb_dest_wen),
        .wb_data       (wb_data),
        .wb_trap_valid (wb_trap_valid),
        .wb_trap_cause (wb_trap_cause),
        .wb_trap_tval  (wb_trap_tval)
    );

endmodule

//--- design/lsu_wb_stage.sv
//****************************
// lsu write-back stage
// result select, trap encoding and the write-back register
//****************************
`timescale 1ns/1ps

module lsu_wb_stage
    import lsu_bus_pkg::*, lsu_op_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ex_ready,
    input  lsu_op_e     ex_op,
    input  axi_addr_t   ex_operand,
    input  pc_t         ex_pc,
    input  reg_idx_t    ex_rd,
    input  logic        ex_dest_wen,
    input  logic        misaligned,
    input  logic        read_err,
    input  logic        write_err,
    input  axi_data_t   load_data,
    input  logic        wb_ready,
    output logic        wb_valid,
    output pc_t         wb_pc,
    output reg_idx_t    wb_rd,
    output logic        wb_dest_wen,
    output axi_data_t   wb_data,
    output logic        wb_trap_valid,
    output trap_cause_t wb_trap_cause,
    output axi_addr_t   wb_trap_tval
);

    logic        is_load;
    logic        bus_err;
    logic        trap;
    trap_cause_t cause;
    axi_data_t   result;

    assign is_load = (ex_op == OP_LOAD);
    assign bus_err = (is_load & read_err) | ((ex_op == OP_STORE) & write_err);
    assign trap    = misaligned | bus_err;

    // misalignment takes priority over a bus error
    always_comb begin
        if (misaligned) begin
            cause = is_load ? CAUSE_LOAD_MISALIGNED : CAUSE_STORE_MISALIGNED;
        end else begin
            cause = is_load ? CAUSE_LOAD_ACCESS : CAUSE_STORE_ACCESS;
        end
    end

    always_comb begin
        case (ex_op)
            OP_LOAD:  result = load_data;
            OP_STORE: result = '0;
            default:  result = ex_operand;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (ex_ready) begin
            wb_valid <= 1'b1;
        end else if (wb_ready) begin
            wb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_ready) begin
            wb_pc         <= ex_pc;
            wb_rd         <= ex_rd;
            wb_dest_wen   <= ex_dest_wen & ~trap;
            wb_data       <= result;
            wb_trap_valid <= trap;
            wb_trap_cause <= trap ? cause : '0;
            wb_trap_tval  <= trap ? ex_operand : '0;
        end
    end

endmodule

//--- design/lsu_write_channel.sv
//****************************
// lsu write channel
// AXI4-Lite write FSM, aw and w handshakes run independently
//****************************
`timescale 1ns/1ps

module lsu_write_channel
    import lsu_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_write,
    input  logic      ex_ready,
    input  axi_addr_t ex_operand,
    input  axi_strb_t wstrb_in,
    input  axi_data_t wdata_in,
    input  logic      awready,
    input  logic      wready,
    input  logic      bvalid,
    input  axi_resp_t bresp,
    output logic      awvalid,
    output axi_addr_t awaddr,
    output logic      wvalid,
    output axi_strb_t wstrb,
    output axi_data_t wdata,
    output logic      bready,
    output logic      write_idle,
    output logic      write_done,
    output logic      write_err
);

    typedef enum logic [2:0] {
        W_IDLE,
        W_BOTH,
        W_AW,
        W_W,
        W_RESP,
        W_DONE
    } wr_state_e;

    wr_state_e state;

    assign awaddr     = ex_operand;
    assign bready     = 1'b1;
    assign write_idle = (state == W_IDLE);
    assign write_done = (state == W_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= W_IDLE;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            write_err <= 1'b0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (start_write) begin
                        state   <= W_BOTH;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                    end
                end
                W_BOTH: begin
                    if (awready && wready) begin
                        state   <= W_RESP;
                        awvalid <= 1'b0;
                        wvalid  <= 1'b0;
                    end else if (awready) begin
                        state   <= W_W;
                        awvalid <= 1'b0;
                    end else if (wready) begin
                        state  <= W_AW;
                        wvalid <= 1'b0;
                    end
                end
                // one side already taken, wait for the other
                W_AW: begin
                    if (awready) begin
                        state   <= W_RESP;
                        awvalid <= 1'b0;
                    end
                end
                W_W: begin
                    if (wready) begin
                        state  <= W_RESP;
                        wvalid <= 1'b0;
                    end
                end
                W_RESP: begin
                    if (bvalid) begin
                        state     <= W_DONE;
                        write_err <= (bresp != RESP_OKAY);
                    end
                end
                W_DONE: begin
                    if (ex_ready) begin
                        state     <= W_IDLE;
                        write_err <= 1'b0;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // lanes latched with the request
    always_ff @(posedge clk) begin
        if (start_write) begin
            wstrb <= wstrb_in;
            wdata <= wdata_in;
        end
    end

endmodule

//--- verif/lsu_tb.sv
//****************************
// lsu testbench
// table driven loads, stores, traps and bus errors against a
// randomly delayed AXI4-Lite memory with write-back stalls
//****************************
`timescale 1ns/1ps

module lsu_tb
    import lsu_bus_pkg::*, lsu_op_pkg::*;
();

    logic clk, rst_n;
    logic ex_valid, ex_ready, ex_signed, ex_dest_wen;
    lsu_op_e ex_op;
    lsu_size_e ex_size;
    axi_addr_t ex_operand;
    axi_data_t ex_store_data;
    reg_idx_t ex_rd;
    pc_t ex_pc;
    logic wb_valid, wb_ready, wb_dest_wen, wb_trap_valid;
    pc_t wb_pc;
    reg_idx_t wb_rd;
    axi_data_t wb_data;
    trap_cause_t wb_trap_cause;
    axi_addr_t wb_trap_tval;
    logic arvalid, arready, rvalid, rready, awvalid, awready, wvalid, wready, bvalid, bready;
    axi_addr_t araddr, awaddr;
    axi_resp_t rresp, bresp;
    axi_data_t rdata, wdata;
    axi_strb_t wstrb;

    // stimulus and expected values per row
    lsu_op_e     t_op [64];
    lsu_size_e   t_size [64];
    logic        t_sgn [64];
    axi_addr_t   t_addr [64];
    axi_data_t   t_sdata [64];
    axi_resp_t   t_resp [64];
    axi_data_t   e_data [64];
    logic        e_trap [64];
    trap_cause_t e_cause [64];
    logic        e_bus [64];
    logic        bus_seen [64];
    int n_rows, drv_idx, chk_idx, row_errs, pass_count, fail_count;
    int cycle_count, cycle_limit;
    logic [31:0] lfsr_state = 32'd75737;
    axi_data_t mem [16];
    axi_data_t model_mem [16];
    logic aw_taken, w_taken;
    axi_addr_t w_addr;
    axi_data_t w_data;
    axi_strb_t w_strb;

    lsu_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic int rand_bits(int n);
        int v;
        int k;
        v = 0;
        for (k = 0; k < n; k++) begin
            v = (v << 1) | lfsr_state[0];
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic axi_data_t fill_word(int idx);
        axi_data_t w;
        int a;
        for (int j = 0; j < 8; j++) begin
            a = idx * 8 + j;
            w[8*j +: 8] = 8'((a * 37 + 11) ^ (a << 3));
        end
        return w;
    endfunction

    //****************************
    // table and reference model
    //****************************
    task automatic add_row(lsu_op_e op, lsu_size_e size, logic sgn, axi_addr_t addr,
                           axi_data_t sdata, axi_resp_t resp);
        int nbytes;
        int b;
        logic mis;
        logic [3:0] idx;
        axi_data_t lane;
        nbytes = 1 << size;
        idx = addr[6:3];
        mis = (op != OP_NONE) && ((addr % nbytes) != 0);
        t_op[n_rows] = op;
        t_size[n_rows] = size;
        t_sgn[n_rows] = sgn;
        t_addr[n_rows] = addr;
        t_sdata[n_rows] = sdata;
        t_resp[n_rows] = resp;
        e_data[n_rows] = '0;
        e_trap[n_rows] = 1'b0;
        e_cause[n_rows] = '0;
        e_bus[n_rows] = (op != OP_NONE) && !mis;
        bus_seen[n_rows] = 1'b0;
        if (op == OP_NONE) begin
            e_data[n_rows] = addr;
        end else if (mis) begin
            e_trap[n_rows] = 1'b1;
            e_cause[n_rows] = (op == OP_LOAD) ? 64'd4 : 64'd6;
        end else if (resp != 2'b00) begin
            e_trap[n_rows] = 1'b1;
            e_cause[n_rows] = (op == OP_LOAD) ? 64'd5 : 64'd7;
        end else if (op == OP_LOAD) begin
            lane = model_mem[idx] >> (8 * addr[2:0]);
            for (b = nbytes; b < 8; b++) begin
                lane[8*b +: 8] = (sgn && lane[8*nbytes-1]) ? 8'hff : 8'h00;
            end
            e_data[n_rows] = lane;
        end else begin
            for (b = 0; b < nbytes; b++) begin
                model_mem[idx][8*(addr[2:0]+b) +: 8] = sdata[8*b +: 8];
            end
        end
        n_rows++;
    endtask

    task automatic build_table();
        int k;
        int off;
        for (k = 0; k < 2; k++) begin
            for (off = 0; off < 8; off++) begin
                add_row(OP_LOAD, SIZE_BYTE, k[0], 64'h18 + off, '0, 2'b00);
            end
            for (off = 0; off < 8; off += 2) begin
                add_row(OP_LOAD, SIZE_HALF, k[0], 64'h20 + off, '0, 2'b00);
            end
            for (off = 0; off < 8; off += 4) begin
                add_row(OP_LOAD, SIZE_WORD, k[0], 64'h28 + off, '0, 2'b00);
            end
            add_row(OP_LOAD, SIZE_DOUBLE, k[0], 64'h30, '0, 2'b00);
        end
        // each store read back as a double word
        add_row(OP_STORE, SIZE_BYTE, 1'b0, 64'h43, 64'h1122_3344_5566_77a7, 2'b00);
        add_row(OP_LOAD, SIZE_DOUBLE, 1'b0, 64'h40, '0, 2'b00);
        add_row(OP_STORE, SIZE_HALF, 1'b0, 64'h4a, 64'h8899_aabb_ccdd_c35a, 2'b00);
        add_row(OP_LOAD, SIZE_DOUBLE, 1'b0, 64'h48, '0, 2'b00);
        add_row(OP_STORE, SIZE_WORD, 1'b0, 64'h54, 64'h0102_0304_f00d_cafe, 2'b00);
        add_row(OP_LOAD, SIZE_DOUBLE, 1'b0, 64'h50, '0, 2'b00);
        add_row(OP_STORE, SIZE_DOUBLE, 1'b0, 64'h58, 64'hfedc_ba98_7654_3210, 2'b00);
        add_row(OP_LOAD, SIZE_DOUBLE, 1'b0, 64'h58, '0, 2'b00);
        // misaligned
        add_row(OP_LOAD, SIZE_HALF, 1'b1, 64'h21, '0, 2'b00);
        add_row(OP_LOAD, SIZE_WORD, 1'b0, 64'h22, '0, 2'b00);
        add_row(OP_LOAD, SIZE_DOUBLE, 1'b0, 64'h2c, '0, 2'b00);
        add_row(OP_STORE, SIZE_HALF, 1'b0, 64'h31, 64'h55, 2'b00);
        add_row(OP_STORE, SIZE_WORD, 1'b0, 64'h36, 64'h66, 2'b00);
        add_row(OP_STORE, SIZE_DOUBLE, 1'b0, 64'h3c, 64'h77, 2'b00);
        // slverr and decerr
        add_row(OP_LOAD, SIZE_DOUBLE, 1'b0, 64'h60, '0, 2'b10);
        add_row(OP_LOAD, SIZE_HALF, 1'b1, 64'h12, '0, 2'b11);
        add_row(OP_STORE, SIZE_WORD, 1'b0, 64'h64, 64'h1234_5678, 2'b10);
        add_row(OP_STORE, SIZE_DOUBLE, 1'b0, 64'h68, 64'h9abc_def0, 2'b11);
        add_row(OP_LOAD, SIZE_DOUBLE, 1'b0, 64'h68, '0, 2'b00);
        // pass-through
        add_row(OP_NONE, SIZE_DOUBLE, 1'b0, 64'hdead_beef_0123_4567, '0, 2'b00);
        add_row(OP_NONE, SIZE_WORD, 1'b1, 64'h0000_0000_0000_0073, '0, 2'b00);
    endtask

    //****************************
    // checks
    //****************************
    task automatic compare_data(string name, axi_data_t got, axi_data_t exp);
        if (got !== exp) begin
            $display("Mismatch %s row %0d got %h expected %h", name, chk_idx, got, exp);
            row_errs++;
        end
    endtask

    task automatic compare_addr(string name, axi_addr_t got, axi_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch %s row %0d got %h expected %h", name, chk_idx, got, exp);
            row_errs++;
        end
    endtask

    task automatic compare_pc(string name, pc_t got, pc_t exp);
        if (got !== exp) begin
            $display("Mismatch %s row %0d got %h expected %h", name, chk_idx, got, exp);
            row_errs++;
        end
    endtask

    task automatic compare_rd(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            $display("Mismatch %s row %0d got %h expected %h", name, chk_idx, got, exp);
            row_errs++;
        end
    endtask

    task automatic compare_cause(string name, trap_cause_t got, trap_cause_t exp);
        if (got !== exp) begin
            $display("Mismatch %s row %0d got %h expected %h", name, chk_idx, got, exp);
            row_errs++;
        end
    endtask

    task automatic compare_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch %s row %0d got %h expected %h", name, chk_idx, got, exp);
            row_errs++;
        end
    endtask

    task automatic check_row();
        int i;
        i = chk_idx;
        if (i >= n_rows) begin
            $display("write-back produced a result beyond the end of the table");
            fail_count++;
        end else begin
            compare_pc("wb_pc", wb_pc, 64'h1000 + 64'(4 * i));
            compare_rd("wb_rd", wb_rd, reg_idx_t'(i));
            compare_flag("wb_trap_valid", wb_trap_valid, e_trap[i]);
            compare_flag("wb_dest_wen", wb_dest_wen, (t_op[i] != OP_STORE) && !e_trap[i]);
            compare_flag("bus_valid", bus_seen[i], e_bus[i]);
            if (e_trap[i]) begin
                compare_cause("wb_trap_cause", wb_trap_cause, e_cause[i]);
                compare_addr("wb_trap_tval", wb_trap_tval, t_addr[i]);
            end else begin
                compare_data("wb_data", wb_data, e_data[i]);
            end
            if (row_errs == 0) begin
                pass_count++;
                $display("row %0d passed", i);
            end else begin
                fail_count++;
                $display("row %0d failed with %0d errors", i, row_errs);
            end
        end
        row_errs = 0;
        chk_idx++;
    endtask

    //****************************
    // main sequence
    //****************************
    initial begin
        rst_n = 1'b0;
        ex_valid = 1'b0;
        ex_op = OP_NONE;
        ex_size = SIZE_BYTE;
        ex_signed = 1'b0;
        ex_operand = '0;
        ex_store_data = '0;
        ex_rd = '0;
        ex_dest_wen = 1'b0;
        ex_pc = '0;
        wb_ready = 1'b0;
        arready = 1'b0;
        rvalid = 1'b0;
        rresp = '0;
        rdata = '0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = '0;
        aw_taken = 1'b0;
        w_taken = 1'b0;
        drv_idx = 0;
        chk_idx = 0;
        row_errs = 0;
        pass_count = 0;
        fail_count = 0;
        n_rows = 0;
        for (int j = 0; j < 16; j++) begin
            mem[j] = fill_word(j);
            model_mem[j] = fill_word(j);
        end
        build_table();
        // reset cycles on top
        cycle_limit = n_rows * 20 + 8;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < n_rows; i++) begin
            drv_idx = i;
            ex_valid <= 1'b1;
            ex_op <= t_op[i];
            ex_size <= t_size[i];
            ex_signed <= t_sgn[i];
            ex_operand <= t_addr[i];
            ex_store_data <= t_sdata[i];
            ex_rd <= reg_idx_t'(i);
            // stores write no register
            ex_dest_wen <= (t_op[i] != OP_STORE);
            ex_pc <= 64'h1000 + 64'(4 * i);
            do begin
                @(posedge clk);
                if (arvalid || awvalid || wvalid) begin
                    bus_seen[i] = 1'b1;
                end
            end while (!ex_ready);
        end
        ex_valid <= 1'b0;
        wait (chk_idx >= n_rows);
        @(posedge clk);
        $display("rows passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_count = 0;
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run hung", cycle_count);
        $display("** FAIL **");
        $finish;
    end

    // write-back consumer with random stalls
    initial begin : wb_checker
        logic stalled;
        pc_t held_pc;
        axi_data_t held_data;
        stalled = 1'b0;
        forever begin
            @(posedge clk);
            if (stalled) begin
                compare_flag("wb_valid", wb_valid, 1'b1);
                compare_pc("wb_pc", wb_pc, held_pc);
                compare_data("wb_data", wb_data, held_data);
            end
            stalled = wb_valid && !wb_ready;
            held_pc = wb_pc;
            held_data = wb_data;
            if (wb_valid && wb_ready) begin
                check_row();
            end
            wb_ready <= (rand_bits(2) != 0);
        end
    end

    //****************************
    // memory responder
    //****************************
    initial begin : read_responder
        logic [3:0] idx;
        axi_resp_t resp;
        forever begin
            @(posedge clk);
            if (arvalid) begin
                compare_addr("araddr", araddr, t_addr[drv_idx]);
                idx = araddr[6:3];
                resp = t_resp[drv_idx];
                repeat (rand_bits(2)) @(posedge clk);
                arready <= 1'b1;
                @(posedge clk);
                arready <= 1'b0;
                repeat (rand_bits(2)) @(posedge clk);
                rvalid <= 1'b1;
                rdata <= mem[idx];
                rresp <= resp;
                @(posedge clk);
                compare_flag("rready", rready, 1'b1);
                rvalid <= 1'b0;
            end
        end
    end

    initial begin : aw_responder
        forever begin
            @(posedge clk);
            if (awvalid) begin
                repeat (rand_bits(2)) @(posedge clk);
                awready <= 1'b1;
                @(posedge clk);
                awready <= 1'b0;
                compare_addr("awaddr", awaddr, t_addr[drv_idx]);
                w_addr = awaddr;
                aw_taken = 1'b1;
            end
        end
    end

    initial begin : w_responder
        forever begin
            @(posedge clk);
            if (wvalid) begin
                repeat (rand_bits(2)) @(posedge clk);
                wready <= 1'b1;
                @(posedge clk);
                wready <= 1'b0;
                w_data = wdata;
                w_strb = wstrb;
                w_taken = 1'b1;
            end
        end
    end

    // memory only written on an okay response
    initial begin : b_responder
        int j;
        forever begin
            @(posedge clk);
            if (aw_taken && w_taken) begin
                aw_taken = 1'b0;
                w_taken = 1'b0;
                if (t_resp[drv_idx] == RESP_OKAY) begin
                    for (j = 0; j < STRB_W; j++) begin
                        if (w_strb[j]) begin
                            mem[w_addr[6:3]][8*j +: 8] = w_data[8*j +: 8];
                        end
                    end
                end
                repeat (rand_bits(2)) @(posedge clk);
                bvalid <= 1'b1;
                bresp <= t_resp[drv_idx];
                @(posedge clk);
                compare_flag("bready", bready, 1'b1);
                bvalid <= 1'b0;
            end
        end
    end

endmodule
